// File: lsu_demo.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_request_decode.sv
logic/lsu_bus_ctrl.sv
logic/lsu_load_result.sv
logic/lsu_top.sv
tb/tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu_demo

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_request_decode.sv
      - logic/lsu_bus_ctrl.sv
      - logic/lsu_load_result.sv
      - logic/lsu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_lsu_top.sv

// File: tb/tb_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu_top;

  localparam int NUM_INSTR     = 400;
  localparam int READY_TIMEOUT = 64;
  localparam int DRAIN_TIMEOUT = 32;

  logic               clk;
  logic               rst_n;
  logic               req_valid_i, req_we_i, req_sext_i, req_ready_o;
  lsu_pkg::lsu_size_e req_size_i;
  logic [31:0]        op_a_i, op_b_i, req_wdata_i, rsp_rdata_o;
  logic               rsp_valid_o, rsp_err_o, busy_o;
  logic               data_req_o, data_we_o, data_gnt_i, data_rvalid_i, data_err_i;
  logic [31:0]        data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]         data_be_o;

  logic [31:0] lfsr_q;
  // Byte-level reference memory and the word memory behind the bus
  logic [7:0]  ref_mem [256];
  logic [31:0] bus_mem [64];
  // Granted transactions in order, with due cycle, read data and error
  int unsigned q_due [$];
  logic [31:0] q_rdata [$];
  logic        q_err [$];
  // Instructions still waiting for their response
  logic [31:0] exp_rdata [$];
  logic        exp_we [$];
  int          exp_ntr [$];
  // Instruction on the request port
  logic [31:0] cur_addr;
  int          cur_n, cur_phase, cur_nphase;
  logic        ready_seen;
  // Address phase left waiting in the previous cycle
  logic        stall_q;
  logic [31:0] stall_addr, stall_wdata;
  logic [3:0]  stall_be;
  logic        stall_we;
  int unsigned cyc;
  int          rsp_cnt;
  logic        err_acc;

  lsu_top UUT (.*);

  always #4 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, sig, got, exp));
  endtask

  ////////////////////
  // Bus memory side
  ////////////////////

  // Stall grants at random, answer the oldest transaction once it is due
  task automatic drive_bus();
    logic [31:0] r;
    draw(2, r);
    data_gnt_i    = (r != 0);
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    if (q_due.size() != 0) begin
      if (q_due[0] <= cyc) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = q_rdata[0];
        data_err_i    = q_err[0];
      end
    end
  endtask

  // Checks on settled signals, and what the coming edge will do
  task automatic check_cycle();
    logic        accepted;
    logic [31:0] word, b, exp_addr, exp_wd, mask, r;
    logic [3:0]  exp_be;
    accepted = data_req_o && data_gnt_i;
    if (stall_q) begin
      assert (data_req_o) else abort_run("Bus request dropped before its grant");
      assert (data_addr_o == stall_addr) else mismatch("data_addr_o", data_addr_o, stall_addr);
      assert (data_be_o == stall_be) else mismatch("data_be_o", data_be_o, stall_be);
      assert (data_we_o == stall_we) else mismatch("data_we_o", data_we_o, stall_we);
      assert (data_wdata_o == stall_wdata)
        else mismatch("data_wdata_o", data_wdata_o, stall_wdata);
    end
    stall_q     = data_req_o && !data_gnt_i;
    stall_addr  = data_addr_o;
    stall_be    = data_be_o;
    stall_we    = data_we_o;
    stall_wdata = data_wdata_o;
    assert (req_valid_i || !data_req_o) else abort_run("Bus request with no core request");
    assert (!data_req_o || q_due.size() < `LSU_MAX_OUTSTANDING)
      else abort_run("Bus request while the outstanding limit is reached");
    assert (busy_o == (q_due.size() != 0)) else mismatch("busy_o", busy_o, q_due.size() != 0);
    assert (req_ready_o == (accepted && cur_phase == cur_nphase - 1))
      else mismatch("req_ready_o", req_ready_o, accepted && cur_phase == cur_nphase - 1);
    // Responses in order, one per instruction on its last read-valid
    if (data_rvalid_i) begin
      rsp_cnt++;
      err_acc = err_acc | q_err[0];
      void'(q_due.pop_front());
      void'(q_rdata.pop_front());
      void'(q_err.pop_front());
      assert (rsp_valid_o == (rsp_cnt == exp_ntr[0]))
        else mismatch("rsp_valid_o", rsp_valid_o, rsp_cnt == exp_ntr[0]);
      if (rsp_cnt == exp_ntr[0]) begin
        assert (rsp_err_o == err_acc) else mismatch("rsp_err_o", rsp_err_o, err_acc);
        if (!exp_we[0]) begin
          assert (rsp_rdata_o == exp_rdata[0])
            else mismatch("rsp_rdata_o", rsp_rdata_o, exp_rdata[0]);
        end
        void'(exp_rdata.pop_front());
        void'(exp_we.pop_front());
        void'(exp_ntr.pop_front());
        rsp_cnt = 0;
        err_acc = 1'b0;
      end
    end else begin
      assert (!rsp_valid_o) else abort_run("Response without a read-valid");
    end
    if (accepted) begin
      // Bytes of the access that fall into this phase's word
      word   = (cur_addr >> 2) + cur_phase;
      exp_be = '0;
      exp_wd = '0;
      mask   = '0;
      for (int k = 0; k < cur_n; k++) begin
        b = cur_addr + k;
        if ((b >> 2) == word) begin
          exp_be[b[1:0]]        = 1'b1;
          exp_wd[8*b[1:0] +: 8] = req_wdata_i[8*k +: 8];
          mask[8*b[1:0] +: 8]   = 8'hff;
        end
      end
      exp_addr = (cur_phase != 0) ? {cur_addr[31:2], 2'b00} + 32'd4 : cur_addr;
      assert (data_addr_o == exp_addr) else mismatch("data_addr_o", data_addr_o, exp_addr);
      assert (data_be_o == exp_be) else mismatch("data_be_o", data_be_o, exp_be);
      assert (data_we_o == req_we_i) else mismatch("data_we_o", data_we_o, req_we_i);
      assert ((data_wdata_o & mask) == exp_wd)
        else mismatch("data_wdata_o", data_wdata_o & mask, exp_wd);
      if (data_we_o) begin
        for (int l = 0; l < 4; l++)
          if (data_be_o[l])
            bus_mem[data_addr_o[7:2]][8*l +: 8] = data_wdata_o[8*l +: 8];
      end
      draw(2, r);
      q_due.push_back(cyc + 1 + r % 3);
      q_rdata.push_back(bus_mem[data_addr_o[7:2]]);
      // Rare bus error
      draw(4, r);
      q_err.push_back(r == 0);
      cur_phase++;
      ready_seen = req_ready_o;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    check_cycle();
    @(posedge clk);
    cyc++;
    #1;
    drive_bus();
  endtask

  ////////////////////
  // Core requests
  ////////////////////

  // New instruction, with its expected response from the byte model
  task automatic issue();
    logic [31:0] r, v;
    draw(1, r);
    req_we_i = r[0];
    draw(2, r);
    case (r[1:0])
      2'd0: begin
        req_size_i = lsu_pkg::SIZE_BYTE;
        cur_n      = 1;
      end
      2'd1: begin
        req_size_i = lsu_pkg::SIZE_HALF;
        cur_n      = 2;
      end
      default: begin
        req_size_i = lsu_pkg::SIZE_WORD;
        cur_n      = 4;
      end
    endcase
    draw(1, r);
    req_sext_i = r[0];
    // Sum stays inside a 64-word window
    draw(7, r);
    op_a_i = 32'h0000_1000 | r;
    draw(7, r);
    op_b_i = r;
    draw(32, r);
    req_wdata_i = r;
    cur_addr   = op_a_i + op_b_i;
    cur_nphase = ((cur_n == 4 && cur_addr[1:0] != 0) ||
                  (cur_n == 2 && cur_addr[1:0] == 3)) ? 2 : 1;
    cur_phase  = 0;
    ready_seen = 1'b0;
    v = '0;
    for (int k = 0; k < cur_n; k++) begin
      if (req_we_i)
        ref_mem[8'(cur_addr + k)] = req_wdata_i[8*k +: 8];
      else
        v[8*k +: 8] = ref_mem[8'(cur_addr + k)];
    end
    if (req_sext_i && cur_n == 1) v = {{24{v[7]}}, v[7:0]};
    if (req_sext_i && cur_n == 2) v = {{16{v[15]}}, v[15:0]};
    exp_rdata.push_back(v);
    exp_we.push_back(req_we_i);
    exp_ntr.push_back(cur_nphase);
    req_valid_i = 1'b1;
  endtask

  initial begin
    int          t;
    logic [31:0] r;
    clk = 1'b0;
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_size_i = lsu_pkg::SIZE_BYTE;
    req_sext_i = 1'b0;
    op_a_i = '0;
    op_b_i = '0;
    req_wdata_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    data_err_i = 1'b0;
    lfsr_q = 32'h183b2b29;
    cyc = 0;
    stall_q = 1'b0;
    rsp_cnt = 0;
    err_acc = 1'b0;
    cur_phase = 0;
    cur_nphase = 0;
    for (int a = 0; a < 256; a++) ref_mem[a] = 8'(a * 75 + 29);
    for (int w = 0; w < 64; w++)
      bus_mem[w] = {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]};
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle after reset
    @(negedge clk);
    assert (!busy_o && !data_req_o && !req_ready_o && !rsp_valid_o)
      else abort_run("Outputs active after reset with no request");
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_INSTR; i++) begin
      issue();
      t = 0;
      while (!ready_seen) begin
        if (t == READY_TIMEOUT) abort_run("Timeout waiting for req_ready_o");
        run_cycle();
        t++;
      end
      // Occasional idle cycle between instructions
      draw(2, r);
      if (r[1:0] == 0) begin
        req_valid_i = 1'b0;
        run_cycle();
      end
    end
    req_valid_i = 1'b0;
    t = 0;
    while (exp_ntr.size() != 0) begin
      if (t == DRAIN_TIMEOUT) abort_run("Timeout waiting for the last responses");
      run_cycle();
      t++;
    end
    // Nothing left in flight once the last response is out
    @(negedge clk);
    assert (!busy_o && !data_req_o && !req_ready_o && !rsp_valid_o)
      else abort_run("Outputs still active after the last response");
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // Core request
  input  logic                   req_valid_i,
  input  logic                   req_we_i,
  input  lsu_pkg::lsu_size_e     req_size_i,
  input  logic                   req_sext_i,
  input  logic [`LSU_DATA_W-1:0] op_a_i,
  input  logic [`LSU_DATA_W-1:0] op_b_i,
  input  logic [`LSU_DATA_W-1:0] req_wdata_i,
  output logic                   req_ready_o,

  // Core response
  output logic                   rsp_valid_o,
  output logic [`LSU_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic                   busy_o,

  // Data bus
  output logic                   data_req_o,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic                   data_err_i
);

  // Address phase accepted on the bus
  logic               accept;
  // Current phase is the first of two
  logic               split;
  lsu_pkg::lsu_info_t info;

  // Write enable rides with the request unchanged
  assign data_we_o = req_we_i;

  lsu_request_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_size_i  (req_size_i),
    .req_sext_i  (req_sext_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .req_wdata_i (req_wdata_i),
    .accept_i    (accept),
    .addr_o      (data_addr_o),
    .be_o        (data_be_o),
    .wdata_o     (data_wdata_o),
    .split_o     (split),
    .info_o      (info)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .split_i       (split),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .accept_o      (accept),
    .req_ready_o   (req_ready_o),
    .busy_o        (busy_o)
  );

  lsu_load_result u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (accept),
    .info_i        (info),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_err_o     (rsp_err_o)
  );

endmodule

// File: logic/lsu_load_result.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_load_result (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  lsu_pkg::lsu_info_t     info_i,
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic                   data_err_i,
  output logic                   rsp_valid_o,
  output logic [`LSU_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o
);

  localparam int PTR_W = $clog2(`LSU_MAX_OUTSTANDING);

  // One entry per transaction in flight
  lsu_pkg::lsu_info_t queue_q [`LSU_MAX_OUTSTANDING];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  // Entry that the current read-valid answers
  lsu_pkg::lsu_info_t head;

  // First half of a split access
  logic [`LSU_DATA_W-1:0]   rdata_q;
  logic                     err_q;

  logic                     joined;
  logic [2*`LSU_DATA_W-1:0] rdata_full;
  logic [2*`LSU_DATA_W-1:0] rdata_aligned;

  ////////////////////
  // Info queue
  ////////////////////

  // Read-valid trails grant by a cycle, so push and pop never meet on one slot
  always_ff @(posedge clk) begin
    if (push_i) begin
      queue_q[wr_ptr_q] <= info_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (data_rvalid_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  assign head = queue_q[rd_ptr_q];

  ////////////////////
  // First half capture
  ////////////////////

  // Data of a load's first half
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !head.last && !head.we) begin
      rdata_q <= data_rdata_i;
    end
  end

  // Error held until the instruction's last response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (data_rvalid_i) begin
      err_q <= head.last ? 1'b0 : data_err_i;
    end
  end

  ////////////////////
  // Realign and extend
  ////////////////////

  // Same crossing rule as the request side
  assign joined = ((head.size == lsu_pkg::SIZE_WORD) && (head.offset != 2'b00)) ||
                  ((head.size == lsu_pkg::SIZE_HALF) && (head.offset == 2'b11));

  // Unsplit data is doubled so that the top lanes wrap into place
  assign rdata_full    = joined ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};
  assign rdata_aligned = rdata_full >> {head.offset, 3'b000};

  always_comb begin
    case (head.size)
      lsu_pkg::SIZE_BYTE:
        rsp_rdata_o = {{24{head.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      lsu_pkg::SIZE_HALF:
        rsp_rdata_o = {{16{head.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:
        rsp_rdata_o = rdata_aligned[`LSU_DATA_W-1:0];
    endcase
  end

  // One response per instruction
  assign rsp_valid_o = data_rvalid_i && head.last;
  assign rsp_err_o   = data_err_i || err_q;

endmodule

// File: logic/lsu_bus_ctrl.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_bus_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid_i,
  input  logic split_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic accept_o,
  output logic req_ready_o,
  output logic busy_o
);

  // Transactions granted and still waiting for read-valid
  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  // Room for one more transaction on the bus
  logic                  has_room;

  ////////////////////
  // Request and grant
  ////////////////////

  // Count only drops while waiting, so a raised request stays up
  assign has_room = (cnt_q < `LSU_CNT_W'(`LSU_MAX_OUTSTANDING));

  // No path from read-valid into the request
  assign data_req_o = req_valid_i && has_room;

  // Address phase done
  assign accept_o = data_req_o && data_gnt_i;

  // Core moves on only after the last address phase
  assign req_ready_o = accept_o && !split_i;

  // Something is still in flight on the bus
  assign busy_o = (cnt_q != '0);

  ////////////////////
  // Outstanding count
  ////////////////////

  // Grant and read-valid may land in the same cycle
  always_comb begin
    case ({accept_o, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: logic/lsu_request_decode.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_request_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  input  logic                   req_we_i,
  input  lsu_pkg::lsu_size_e     req_size_i,
  input  logic                   req_sext_i,
  input  logic [`LSU_DATA_W-1:0] op_a_i,
  input  logic [`LSU_DATA_W-1:0] op_b_i,
  input  logic [`LSU_DATA_W-1:0] req_wdata_i,
  input  logic                   accept_i,
  output logic [`LSU_DATA_W-1:0] addr_o,
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o,
  output logic                   split_o,
  output lsu_pkg::lsu_info_t     info_o
);

  // Effective address and its byte offset within the word
  logic [`LSU_DATA_W-1:0] addr;
  logic [1:0]             offset;
  // Access crosses a word boundary
  logic                   crosses_word;
  lsu_pkg::lsu_phase_e    phase_q;

  assign addr   = op_a_i + op_b_i;
  assign offset = addr[1:0];

  // Word at any nonzero offset, or halfword in the top byte lane
  assign crosses_word = ((req_size_i == lsu_pkg::SIZE_WORD) && (offset != 2'b00)) ||
                        ((req_size_i == lsu_pkg::SIZE_HALF) && (offset == 2'b11));

  // Only the first phase of a crossing access announces a second one
  assign split_o = crosses_word && (phase_q == lsu_pkg::PHASE_FIRST);

  ////////////////////
  // Split phase
  ////////////////////

  // Dropped request returns to the first phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= lsu_pkg::PHASE_FIRST;
    end else if (!req_valid_i) begin
      phase_q <= lsu_pkg::PHASE_FIRST;
    end else if (accept_i) begin
      phase_q <= split_o ? lsu_pkg::PHASE_SECOND : lsu_pkg::PHASE_FIRST;
    end
  end

  ////////////////////
  // Address phase
  ////////////////////

  // Second phase goes to the next word, starting at lane 0
  assign addr_o = (phase_q == lsu_pkg::PHASE_SECOND) ?
                  ({addr[`LSU_DATA_W-1:2], 2'b00} + `LSU_DATA_W'(4)) : addr;

  always_comb begin
    be_o = '0;
    if (phase_q == lsu_pkg::PHASE_FIRST) begin
      case (req_size_i)
        lsu_pkg::SIZE_BYTE: be_o = `LSU_BE_W'(1) << offset;
        lsu_pkg::SIZE_HALF: begin
          // Offset 3 keeps only the top lane here
          case (offset)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
        default: begin
          // Lanes from the offset up to the top
          case (offset)
            2'b00:   be_o = 4'b1111;
            2'b01:   be_o = 4'b1110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
      endcase
    end else begin
      // Tail bytes that spilled past the word boundary
      if (req_size_i == lsu_pkg::SIZE_HALF) begin
        be_o = 4'b0001;
      end else begin
        case (offset)
          2'b01:   be_o = 4'b0001;
          2'b10:   be_o = 4'b0011;
          2'b11:   be_o = 4'b0111;
          default: be_o = 4'b0000;
        endcase
      end
    end
  end

  // Rotate left by the offset, same in both phases
  always_comb begin
    case (offset)
      2'b00:   wdata_o = req_wdata_i;
      2'b01:   wdata_o = {req_wdata_i[23:0], req_wdata_i[31:24]};
      2'b10:   wdata_o = {req_wdata_i[15:0], req_wdata_i[31:16]};
      default: wdata_o = {req_wdata_i[7:0],  req_wdata_i[31:8]};
    endcase
  end

  // Entry pushed into the result queue at grant
  always_comb begin
    info_o.size   = req_size_i;
    info_o.sext   = req_sext_i;
    info_o.we     = req_we_i;
    info_o.offset = offset;
    info_o.last   = !split_o;
  end

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

  ////////////////////
  // Opcodes and states
  ////////////////////

  // Access size as it comes from the decoder
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Which address phase of a split access is on the bus
  typedef enum logic {
    PHASE_FIRST  = 1'b0,
    PHASE_SECOND = 1'b1
  } lsu_phase_e;

  ////////////////////
  // Result queue entry
  ////////////////////

  // Captured at grant, consumed at read-valid
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    // Low only for the first half of a split
    logic       last;
  } lsu_info_t;

endpackage

// File: logic/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

////////////////////
// Datapath widths
////////////////////

// Address and data are the same width on this core
`define LSU_DATA_W 32

// One enable per byte lane of a data word
`define LSU_BE_W 4

////////////////////
// Bus pipelining
////////////////////

// Granted but not yet answered transactions
`define LSU_MAX_OUTSTANDING 2

// Counter must hold 0 up to the limit itself
`define LSU_CNT_W 2

`endif
